// File: hw/dbg_pkg.sv
package dbg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int byte_w = 8;
    localparam int word_w = 32; // xlen and ilen
    localparam int addr_w = 32;

    typedef logic [byte_w-1:0] byte_t; // one spi transfer
    typedef logic [word_w-1:0] word_t;
    typedef logic [addr_w-1:0] addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host command codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam byte_t cmd_nop        = 8'h00;
    localparam byte_t cmd_echo       = 8'h01;
    localparam byte_t cmd_toggle_led = 8'h02;
    localparam byte_t cmd_run        = 8'h03;
    localparam byte_t cmd_halt       = 8'h04;
    localparam byte_t cmd_step       = 8'h05;
    localparam byte_t cmd_get_pc     = 8'h06;
    localparam byte_t cmd_get_insn   = 8'h07;

    // payload bytes of a word reply
    localparam byte_t reply_len = 8'd4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command controller
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        idle,     // waiting for a command byte
        echo,     // next byte goes back unchanged
        replying  // shifting out a word snapshot
    } dbg_state_t;

endpackage

// File: hw/spi_slave.sv
`timescale 1ns/1ps

module spi_slave #(
    parameter int sync_stages = 2
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           sclk,
    input  logic           mosi,
    input  logic           ss,
    output logic           miso,
    input  dbg_pkg::byte_t send_data,
    output dbg_pkg::byte_t recv_data,
    output logic           recv_valid
);

    logic [sync_stages-1:0] sclk_sync;
    logic [sync_stages-1:0] mosi_sync;
    logic [sync_stages-1:0] ss_sync;
    logic                   sclk_s;
    logic                   mosi_s;
    logic                   ss_s;
    logic                   sclk_last;
    logic                   ss_last;
    logic                   sclk_rise;
    logic                   sclk_fall;
    logic                   ss_fall;
    logic [2:0]             bit_cnt;
    logic                   load_q;
    dbg_pkg::byte_t         shift_in;
    dbg_pkg::byte_t         shift_out;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pin synchronizers and edge strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sclk_sync <= '0;
            mosi_sync <= '0;
            ss_sync   <= '1; // deselected
        end else begin
            sclk_sync <= {sclk_sync[sync_stages-2:0], sclk};
            mosi_sync <= {mosi_sync[sync_stages-2:0], mosi};
            ss_sync   <= {ss_sync[sync_stages-2:0], ss};
        end
    end

    assign sclk_s = sclk_sync[sync_stages-1];
    assign mosi_s = mosi_sync[sync_stages-1];
    assign ss_s   = ss_sync[sync_stages-1];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sclk_last <= 1'b0;
            ss_last   <= 1'b1;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
            ss_fall   <= 1'b0;
        end else begin
            sclk_last <= sclk_s;
            ss_last   <= ss_s;
            sclk_rise <= sclk_s & ~sclk_last & ~ss_s;
            sclk_fall <= ~sclk_s & sclk_last & ~ss_s;
            ss_fall   <= ~ss_s & ss_last;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bit_cnt    <= '0;
            recv_valid <= 1'b0;
            load_q     <= 1'b0;
        end else begin
            recv_valid <= 1'b0;
            load_q     <= recv_valid; // reply lands one cycle after recv_valid
            if (ss_s) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7)
                    recv_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            shift_in <= {shift_in[6:0], mosi_s}; // msb first
            if (bit_cnt == 3'd7)
                recv_data <= {shift_in[6:0], mosi_s};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transmit side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            shift_out <= '0;
        end else if (ss_fall || load_q) begin
            shift_out <= send_data;
        end else if (sclk_fall && bit_cnt != 3'd0) begin
            // last falling edge of a byte keeps the freshly loaded msb
            shift_out <= {shift_out[6:0], 1'b0};
        end
    end

    assign miso = shift_out[7];

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter dbg_pkg::word_t reset_pc = '0
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           run,
    input  logic           step,
    output dbg_pkg::word_t pc,
    output dbg_pkg::word_t insn,
    output dbg_pkg::addr_t paddr,
    output logic           psel,
    output logic           penable,
    output logic           pwrite,
    input  dbg_pkg::word_t prdata,
    input  logic           pready
);

    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } fetch_state_t;

    fetch_state_t state;
    logic         step_pend; // one step held during a fetch

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // apb read master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= idle;
            step_pend <= 1'b0;
            pc        <= reset_pc;
            insn      <= '0;
        end else begin
            case (state)
                idle: begin
                    step_pend <= 1'b0;
                    if (step || step_pend || run)
                        state <= setup;
                end
                setup: begin
                    if (step)
                        step_pend <= 1'b1;
                    state <= access;
                end
                access: begin
                    if (step)
                        step_pend <= 1'b1; // extra steps collapse into this one
                    if (pready) begin
                        insn  <= prdata;
                        pc    <= pc + dbg_pkg::word_t'(4);
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    assign psel    = (state != idle);
    assign penable = (state == access);
    assign paddr   = pc; // pc only moves once psel drops
    assign pwrite  = 1'b0; // read only

endmodule

// File: hw/dbg_cmd.sv
`timescale 1ns/1ps

module dbg_cmd (
    input  logic           clk,
    input  logic           rst,
    input  dbg_pkg::byte_t recv_data,
    input  logic           recv_valid,
    input  dbg_pkg::word_t pc,
    input  dbg_pkg::word_t insn,
    output dbg_pkg::byte_t send_data,
    output logic           led,
    output logic           run,
    output logic           step
);

    dbg_pkg::dbg_state_t state;
    dbg_pkg::word_t      snap;      // word being replied
    dbg_pkg::byte_t      reply_cnt; // payload bytes still to go

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= dbg_pkg::idle;
            send_data <= '0;
            reply_cnt <= '0;
            led       <= 1'b0;
            run       <= 1'b0;
            step      <= 1'b0;
        end else begin
            step <= 1'b0; // single cycle pulse
            if (recv_valid) begin
                case (state)
                    dbg_pkg::idle: begin
                        case (recv_data)
                            dbg_pkg::cmd_echo: begin
                                send_data <= dbg_pkg::cmd_echo;
                                state     <= dbg_pkg::echo;
                            end
                            dbg_pkg::cmd_toggle_led: begin
                                send_data <= '0;
                                led       <= ~led;
                            end
                            dbg_pkg::cmd_run: begin
                                send_data <= '0;
                                run       <= 1'b1;
                            end
                            dbg_pkg::cmd_halt: begin
                                send_data <= '0;
                                run       <= 1'b0;
                            end
                            dbg_pkg::cmd_step: begin
                                send_data <= '0;
                                step      <= 1'b1;
                            end
                            dbg_pkg::cmd_get_pc,
                            dbg_pkg::cmd_get_insn: begin
                                send_data <= dbg_pkg::reply_len; // length byte first
                                reply_cnt <= dbg_pkg::reply_len;
                                state     <= dbg_pkg::replying;
                            end
                            default: begin
                                // nop and unknown codes
                                send_data <= '0;
                            end
                        endcase
                    end

                    dbg_pkg::echo: begin
                        send_data <= recv_data;
                        state     <= dbg_pkg::idle;
                    end

                    dbg_pkg::replying: begin
                        // host bytes are don't care here
                        send_data <= snap[31:24];
                        reply_cnt <= reply_cnt - 8'd1;
                        if (reply_cnt == 8'd1)
                            state <= dbg_pkg::idle;
                    end

                    default: begin
                        send_data <= '0;
                        state     <= dbg_pkg::idle;
                    end
                endcase
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reply snapshot, msb first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (recv_valid) begin
            if (state == dbg_pkg::idle) begin
                if (recv_data == dbg_pkg::cmd_get_pc)
                    snap <= pc; // frozen at decode
                else if (recv_data == dbg_pkg::cmd_get_insn)
                    snap <= insn;
            end else if (state == dbg_pkg::replying) begin
                snap <= {snap[23:0], 8'h00};
            end
        end
    end

endmodule

// File: hw/dbg_top.sv
`timescale 1ns/1ps

module dbg_top #(
    parameter dbg_pkg::word_t reset_pc    = '0,
    parameter int             sync_stages = 2
) (
    input  logic           clk,
    input  logic           rst,
    // host spi, mode 0
    input  logic           sclk,
    input  logic           mosi,
    input  logic           ss,
    output logic           miso,
    output logic           led,
    // apb instruction port
    output dbg_pkg::addr_t paddr,
    output logic           psel,
    output logic           penable,
    output logic           pwrite,
    input  dbg_pkg::word_t prdata,
    input  logic           pready
);

    dbg_pkg::byte_t recv_data;
    logic           recv_valid;
    dbg_pkg::byte_t send_data;
    logic           run;
    logic           step;
    dbg_pkg::word_t pc;
    dbg_pkg::word_t insn;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    spi_slave #(
        .sync_stages (sync_stages)
    ) spi_slave_i (
        .clk        (clk),
        .rst        (rst),
        .sclk       (sclk),
        .mosi       (mosi),
        .ss         (ss),
        .miso       (miso),
        .send_data  (send_data),
        .recv_data  (recv_data),
        .recv_valid (recv_valid)
    );

    dbg_cmd dbg_cmd_i (
        .clk        (clk),
        .rst        (rst),
        .recv_data  (recv_data),
        .recv_valid (recv_valid),
        .pc         (pc),
        .insn       (insn),
        .send_data  (send_data),
        .led        (led),
        .run        (run),
        .step       (step)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // target side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    fetch_unit #(
        .reset_pc (reset_pc)
    ) fetch_unit_i (
        .clk     (clk),
        .rst     (rst),
        .run     (run),
        .step    (step),
        .pc      (pc),
        .insn    (insn),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .prdata  (prdata),
        .pready  (pready)
    );

endmodule

// File: sim/dbg_top_chk.sv
`timescale 1ns/1ps

module dbg_top_chk (
    input logic           clk,
    input logic           rst,
    input logic           psel,
    input logic           penable,
    input dbg_pkg::addr_t paddr,
    input logic           run
);

    // access phase only straight out of setup
    penable_after_setup: assert property (
        @(posedge clk) disable iff (!rst)
        $rose(penable) |-> psel && $past(psel)
    ) else $error("penable rose without a preceding setup cycle");

    paddr_stable: assert property (
        @(posedge clk) disable iff (!rst)
        psel && $past(psel) |-> $stable(paddr)
    ) else $error("paddr changed during a transfer");

    run_low_out_of_reset: assert property (
        @(posedge clk) $rose(rst) |-> !run
    ) else $error("run high when leaving reset");

endmodule

bind dbg_top dbg_top_chk dbg_top_chk_i (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .paddr   (paddr),
    .run     (run) // internal to dbg_top
);

// File: sim/tb_dbg_top.sv
`timescale 1ns/1ps

module tb_dbg_top;

    localparam dbg_pkg::word_t reset_pc    = 32'h0000_1000;
    localparam int             sync_stages = 2;
    localparam int             half_period = 10; // clk cycles per sclk phase
    localparam int             xfer_cycles = 170;
    localparam int             n_xfers     = 67;
    localparam int             fetch_allow = 400;
    localparam int             cycle_limit = (3 * (n_xfers * xfer_cycles + fetch_allow)) / 2;

    logic           clk;
    logic           rst;
    logic           sclk;
    logic           mosi;
    logic           ss;
    logic           miso;
    logic           led;
    dbg_pkg::addr_t paddr;
    logic           psel;
    logic           penable;
    logic           pwrite;
    dbg_pkg::word_t prdata;
    logic           pready;

    integer         seed;
    int             wait_left = 0;
    int             cycle_cnt = 0;
    logic           exp_led;
    dbg_pkg::word_t exp_pc;

    dbg_top #(
        .reset_pc    (reset_pc),
        .sync_stages (sync_stages)
    ) dbg_top_i (
        .clk     (clk),
        .rst     (rst),
        .sclk    (sclk),
        .mosi    (mosi),
        .ss      (ss),
        .miso    (miso),
        .led     (led),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .prdata  (prdata),
        .pready  (pready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == cycle_limit) begin
            $display("run timed out after %0d clock cycles", cycle_cnt);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // apb memory model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic dbg_pkg::word_t model_word(input dbg_pkg::addr_t addr);
        return 32'hA5A5_0000 ^ addr;
    endfunction

    always @(negedge clk) begin
        if (psel)
            check_bit(pwrite, 1'b0, "pwrite during fetch"); // fetches only read
        if (psel && penable) begin
            if (wait_left == 0) begin
                pready = 1'b1;
                prdata = model_word(paddr);
            end else begin
                wait_left = wait_left - 1;
                pready    = 1'b0;
            end
        end else begin
            pready = 1'b0;
            if (psel)
                wait_left = $random(seed) & 3; // 0 to 3 wait states
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // spi master and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic spi_xfer(input dbg_pkg::byte_t tx, output dbg_pkg::byte_t rx);
        int i;
        rx = '0;
        ss = 1'b0;
        for (i = 7; i >= 0; i--) begin
            mosi = tx[i]; // mode 0, data set while sclk low
            repeat (half_period) @(negedge clk);
            sclk = 1'b1;
            rx   = {rx[6:0], miso};
            repeat (half_period) @(negedge clk);
            sclk = 1'b0;
        end
        repeat (5) @(negedge clk);
        ss = 1'b1;
        repeat (5) @(negedge clk);
    endtask

    task automatic check_byte(input dbg_pkg::byte_t got, input dbg_pkg::byte_t exp,
                              input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "byte mismatch");
        end
    endtask

    task automatic check_word(input dbg_pkg::word_t got, input dbg_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "bit mismatch");
        end
    endtask

    // command, length byte, then four payload bytes msb first
    task automatic read_word(input dbg_pkg::byte_t cmd, output dbg_pkg::word_t val);
        dbg_pkg::byte_t r;
        int             i;
        spi_xfer(cmd, r);
        check_byte(r, 8'h00, "reply before word command");
        spi_xfer(8'h00, r);
        check_byte(r, 8'h04, "word reply length");
        val = '0;
        for (i = 0; i < 4; i++) begin
            spi_xfer(8'h00, r);
            val = {val[23:0], r};
        end
    endtask

    task automatic wait_fetch_idle();
        repeat (2) @(negedge clk);
        while (psel)
            @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic echo_and_nop();
        dbg_pkg::byte_t r;
        spi_xfer(8'h01, r);
        spi_xfer(8'h5A, r);
        check_byte(r, 8'h01, "echo ack");
        spi_xfer(8'h00, r);
        check_byte(r, 8'h5A, "echoed byte");
    endtask

    task automatic led_toggle();
        dbg_pkg::byte_t r;
        int             i;
        check_bit(led, exp_led, "led after reset");
        for (i = 0; i < 2; i++) begin
            exp_led = ~exp_led;
            spi_xfer(8'h02, r);
            spi_xfer(8'h00, r);
            check_byte(r, 8'h00, "toggle reply");
            check_bit(led, exp_led, "led level");
        end
    endtask

    task automatic step_and_fetch();
        dbg_pkg::byte_t r;
        dbg_pkg::word_t w;
        int             n;
        for (n = 1; n <= 3; n++) begin
            repeat (n) begin
                spi_xfer(8'h05, r);
                check_byte(r, 8'h00, "reply before step");
            end
            wait_fetch_idle();
            exp_pc = exp_pc + 4 * n;
            read_word(8'h06, w);
            check_word(w, exp_pc, "pc after steps");
            read_word(8'h07, w);
            check_word(w, model_word(exp_pc - 4), "last fetched insn");
        end
    endtask

    task automatic run_then_halt();
        dbg_pkg::byte_t r;
        dbg_pkg::word_t w;
        dbg_pkg::word_t w2;
        spi_xfer(8'h03, r);
        repeat (40) @(negedge clk);
        spi_xfer(8'h04, r);
        check_byte(r, 8'h00, "run reply");
        wait_fetch_idle();
        read_word(8'h06, w);
        check_word(w & 32'h3, 32'h0, "pc alignment");
        check_bit(w > exp_pc, 1'b1, "pc moved while running");
        repeat (20) @(negedge clk);
        check_bit(psel, 1'b0, "no fetch after halt");
        read_word(8'h06, w2);
        check_word(w2, w, "pc held after halt");
        exp_pc = w;
    endtask

    task automatic unknown_code();
        dbg_pkg::byte_t r;
        spi_xfer(8'h3C, r);
        spi_xfer(8'h01, r);
        check_byte(r, 8'h00, "unknown code reply");
        spi_xfer(8'hC3, r); // controller must be back in idle
        check_byte(r, 8'h01, "echo ack after unknown code");
        spi_xfer(8'h00, r);
        check_byte(r, 8'hC3, "echoed byte after unknown code");
    endtask

    initial begin
        seed    = 32'h8995;
        rst     = 1'b0;
        sclk    = 1'b0;
        mosi    = 1'b0;
        ss      = 1'b1;
        prdata  = '0;
        pready  = 1'b0;
        exp_led = 1'b0;
        exp_pc  = reset_pc;
        repeat (16) @(negedge clk);
        rst = 1'b1;
        repeat (4) @(negedge clk);
        echo_and_nop();
        led_toggle();
        step_and_fetch();
        run_then_halt();
        unknown_code();
        $display("No errors");
        $finish;
    end

endmodule

// File: sim.f
hw/dbg_pkg.sv
hw/spi_slave.sv
hw/fetch_unit.sv
hw/dbg_cmd.sv
hw/dbg_top.sv
sim/dbg_top_chk.sv
sim/tb_dbg_top.sv

// File: Bender.yml
package:
  name: dbg_top

sources:
  # design
  - files:
      - hw/dbg_pkg.sv
      - hw/spi_slave.sv
      - hw/fetch_unit.sv
      - hw/dbg_cmd.sv
      - hw/dbg_top.sv

  # testbench and bound checks
  - target: simulation
    files:
      - sim/dbg_top_chk.sv
      - sim/tb_dbg_top.sv
